// File: aesKeyExpansion.f
+incdir+.
aesKeyPkg.sv
aesSbox.sv
roundKeyGen.sv
keyExpansionCtrl.sv
roundKeyStore.sv
apbKeyRegs.sv
aesKeyExpansionApb.sv
keyExpansionTb.sv

// File: keyExpansionModel.svh
`ifndef KEY_EXPANSION_MODEL_SVH
`define KEY_EXPANSION_MODEL_SVH

// substitution table rebuilt from field inversion, and the expected words of one key
logic [7:0]           modelSbox [0:255];
logic [wordWidth-1:0] expectedWords [0:numWords-1];

// multiply in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] product;
    logic [7:0] shifted;
    product = 8'h00;
    shifted = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            product = product ^ shifted;
        end
        shifted = {shifted[6:0], 1'b0} ^ (shifted[7] ? 8'h1b : 8'h00);
    end
    return product;
endfunction

function automatic logic [7:0] rotateLeft8(input logic [7:0] value, input int amount);
    logic [15:0] doubled;
    doubled = {value, value};
    return doubled[15 - amount -: 8];
endfunction

task automatic buildModelSbox();
    logic [7:0] inverse;
    for (int x = 0; x < 256; x++) begin
        // zero has no inverse and maps to zero before the affine step
        inverse = 8'h00;
        for (int y = 1; y < 256; y++) begin
            if (gfMul(8'(x), 8'(y)) == 8'h01) begin
                inverse = 8'(y);
            end
        end
        modelSbox[x] = inverse ^ rotateLeft8(inverse, 1) ^ rotateLeft8(inverse, 2) ^
                       rotateLeft8(inverse, 3) ^ rotateLeft8(inverse, 4) ^ 8'h63;
    end
endtask

task automatic expandKey(input logic [keyWidth-1:0] key);
    logic [wordWidth-1:0] temp;
    logic [7:0]           rcon;
    rcon = 8'h01;
    for (int i = 0; i < 4; i++) begin
        expectedWords[i] = key[keyWidth - 1 - wordWidth * i -: wordWidth];
    end
    for (int i = 4; i < numWords; i++) begin
        temp = expectedWords[i - 1];
        if (i % 4 == 0) begin
            temp = {temp[23:0], temp[31:24]};
            temp = {modelSbox[temp[31:24]], modelSbox[temp[23:16]],
                    modelSbox[temp[15:8]], modelSbox[temp[7:0]]};
            temp[31:24] = temp[31:24] ^ rcon;
            rcon = gfMul(rcon, 8'h02);
        end
        expectedWords[i] = expectedWords[i - 4] ^ temp;
    end
endtask

`endif

// File: keyExpansionTb.sv
`timescale 1ns/1ns

module keyExpansionTb import aesKeyPkg::*; ();

    logic                 clk;
    logic                 reset;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [addrWidth-1:0] paddr;
    logic [wordWidth-1:0] pwdata;
    logic [wordWidth-1:0] prdata;
    logic                 pready;
    logic                 pslverr;

    integer               seed;
    int                   errorCount;
    int                   testErrorBase;
    int                   testsPassed;
    int                   testsFailed;
    logic [keyWidth-1:0]  key;
    logic                 startDone;

    `include "keyExpansionModel.svh"

    aesKeyExpansionApb dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    task automatic assertFailed(input string what);
        $display("assertion failed at time %0t: %s", $time, what);
        errorCount++;
    endtask

    // a start write that is accepted, on its completing edge
    assign startDone = psel & penable & pwrite & pready & ~pslverr &
                       (paddr == ctrlAddr) & pwdata[0];

    assert property (@(posedge clk) disable iff (reset)
        startDone |=> (dut_i.busy && !dut_i.done)[*10] ##1 (!dut_i.busy && dut_i.done))
        else assertFailed("busy was not high for exactly 10 cycles before done");
    assert property (@(posedge clk) disable iff (reset)
        (dut_i.done && !startDone) |=> dut_i.done)
        else assertFailed("done fell without a new start");
    assert property (@(posedge clk) disable iff (reset) !(dut_i.busy && dut_i.done))
        else assertFailed("busy and done high together");
    assert property (@(posedge clk) $fell(reset) |->
        (!dut_i.busy && !dut_i.done && !pready && !pslverr))
        else assertFailed("state not idle after reset");
    assert property (@(posedge clk) disable iff (reset) pready |-> (psel && penable))
        else assertFailed("pready outside an access phase");
    assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
        else assertFailed("pslverr without pready");
    assert property (@(posedge clk) disable iff (reset)
        (psel && !penable && !pwrite && paddr >= roundKeyBase) |=>
        (psel && penable && !pready) ##1 (psel && penable && pready))
        else assertFailed("round-key read did not take exactly one wait state");
    assert property (@(posedge clk) disable iff (reset)
        (psel && !penable && (pwrite || paddr < roundKeyBase)) |=> (penable && pready))
        else assertFailed("register access did not finish in its first access cycle");

    task automatic checkWord(input string name, input logic [wordWidth-1:0] expected,
                             input logic [wordWidth-1:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // setup phase, then access phases until pready, inputs moved 1 ns after each edge
    task automatic apbTransfer(input logic write, input logic [addrWidth-1:0] addr,
                               input logic [wordWidth-1:0] wdata,
                               output logic [wordWidth-1:0] rdata, output logic err);
        int waitCount;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waitCount = 0;
        @(negedge clk);
        while (!pready && waitCount < 16) begin
            @(negedge clk);
            waitCount++;
        end
        if (!pready) begin
            $display("timeout: no pready for the transfer to address %h", addr);
            errorCount++;
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic writeExpect(input logic [addrWidth-1:0] addr,
                               input logic [wordWidth-1:0] data, input logic expErr);
        logic [wordWidth-1:0] unused;
        logic                 err;
        apbTransfer(1'b1, addr, data, unused, err);
        checkWord($sformatf("pslverr write %h", addr), 32'(expErr), 32'(err));
    endtask

    task automatic readExpect(input logic [addrWidth-1:0] addr, input string name,
                              input logic [wordWidth-1:0] expected, input logic expErr);
        logic [wordWidth-1:0] data;
        logic                 err;
        apbTransfer(1'b0, addr, '0, data, err);
        checkWord($sformatf("pslverr read %h", addr), 32'(expErr), 32'(err));
        if (!expErr) begin
            checkWord(name, expected, data);
        end
    endtask

    task automatic writeKey(input logic [keyWidth-1:0] value);
        for (int i = 0; i < 4; i++) begin
            writeExpect(keyAddr0 + 12'(4 * i), value[keyWidth - 1 - 32 * i -: 32], 1'b0);
        end
    endtask

    task automatic readKeyRegs(input logic [keyWidth-1:0] value);
        for (int i = 0; i < 4; i++) begin
            readExpect(keyAddr0 + 12'(4 * i), $sformatf("prdata key word %0d", i),
                       value[keyWidth - 1 - 32 * i -: 32], 1'b0);
        end
    endtask

    task automatic waitForDone();
        logic [wordWidth-1:0] status;
        logic                 err;
        int                   polls;
        status = '0;
        polls = 0;
        while (!status[1] && polls < 40) begin
            apbTransfer(1'b0, statusAddr, '0, status, err);
            polls++;
        end
        if (!status[1]) begin
            $display("timeout: the expansion never reported done");
            errorCount++;
        end
    endtask

    task automatic readAllWords();
        for (int n = 0; n < numWords; n++) begin
            readExpect(roundKeyBase + 12'(4 * n), $sformatf("prdata round-key word %0d", n),
                       expectedWords[n], 1'b0);
        end
    endtask

    task automatic expandAndCheck(input logic [keyWidth-1:0] value);
        writeKey(value);
        expandKey(value);
        writeExpect(ctrlAddr, 32'h1, 1'b0);
        waitForDone();
        readAllWords();
    endtask

    task automatic endTest(input string name);
        if (errorCount == testErrorBase) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errorCount - testErrorBase);
        end
        testErrorBase = errorCount;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        seed = 32'h1faf1ac9;
        errorCount = 0;
        testErrorBase = 0;
        testsPassed = 0;
        testsFailed = 0;
        buildModelSbox();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        readExpect(statusAddr, "prdata status", 32'h0, 1'b0);
        key = {32'h01234567, 32'h89abcdef, 32'hfedcba98, 32'h76543210};
        writeKey(key);
        readKeyRegs(key);
        endTest("statusAndReset");

        expandAndCheck(128'h2b7e151628aed2a6abf7158809cf4f3c);
        checkWord("model word 43", 32'hb6630ca6, expectedWords[43]);
        readExpect(roundKeyBase + 12'(4 * 43), "prdata round-key word 43", 32'hb6630ca6, 1'b0);
        endTest("knownVector");

        for (int k = 0; k < 8; k++) begin
            key = {$random(seed), $random(seed), $random(seed), $random(seed)};
            expandAndCheck(key);
        end
        endTest("randomKeys");

        // status shows busy right after the start and only done once finished
        writeExpect(ctrlAddr, 32'h1, 1'b0);
        readExpect(statusAddr, "prdata status", 32'h1, 1'b0);
        waitForDone();
        readExpect(statusAddr, "prdata status", 32'h2, 1'b0);
        endTest("doneTiming");

        key = {$random(seed), $random(seed), $random(seed), $random(seed)};
        writeKey(key);
        expandKey(key);
        writeExpect(ctrlAddr, 32'h1, 1'b0);
        readExpect(roundKeyBase, "prdata round-key word 0", '0, 1'b1);
        writeExpect(keyAddr0, 32'hdeadbeef, 1'b1);
        writeExpect(ctrlAddr, 32'h1, 1'b1);
        waitForDone();
        readKeyRegs(key);
        readAllWords();
        readExpect(12'h020, "prdata unmapped", '0, 1'b1);
        readExpect(roundKeyBase + 12'(4 * numWords), "prdata word 44", '0, 1'b1);
        readKeyRegs(key);
        readExpect(statusAddr, "prdata status", 32'h2, 1'b0);
        endTest("errorResponses");

        repeat (4) @(posedge clk);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: aesKeyExpansionApb.sv
`timescale 1ns/1ns

module aesKeyExpansionApb import aesKeyPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [addrWidth-1:0] paddr,
    input  logic [wordWidth-1:0] pwdata,
    output logic [wordWidth-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic                 busy;
    logic                 done;
    logic                 startPulse;
    roundKeyT             cipherKey;
    logic                 storeWrite;
    roundIdxT             storeRound;
    roundKeyT             storeKey;
    logic                 readEn;
    wordIdxT              readIdx;
    logic [wordWidth-1:0] readWord;

    apbKeyRegs apbRegs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .done       (done),
        .startPulse (startPulse),
        .cipherKey  (cipherKey),
        .readEn     (readEn),
        .readIdx    (readIdx),
        .readWord   (readWord)
    );

    keyExpansionCtrl expCtrl (
        .clk        (clk),
        .reset      (reset),
        .startPulse (startPulse),
        .cipherKey  (cipherKey),
        .busy       (busy),
        .done       (done),
        .storeWrite (storeWrite),
        .storeRound (storeRound),
        .storeKey   (storeKey)
    );

    roundKeyStore keyStore (
        .clk        (clk),
        .writeEn    (storeWrite),
        .writeRound (storeRound),
        .writeKey   (storeKey),
        .readEn     (readEn),
        .readIdx    (readIdx),
        .readWord   (readWord)
    );

endmodule

// File: apbKeyRegs.sv
`timescale 1ns/1ns

module apbKeyRegs import aesKeyPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [addrWidth-1:0] paddr,
    input  logic [wordWidth-1:0] pwdata,
    output logic [wordWidth-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 busy,
    input  logic                 done,
    output logic                 startPulse,
    output roundKeyT             cipherKey,
    output logic                 readEn,
    output wordIdxT              readIdx,
    input  logic [wordWidth-1:0] readWord
);

    logic                   access;
    logic                   isKey;
    logic                   isCtrl;
    logic                   isStatus;
    logic                   isRk;
    logic [addrWidth-1:0]   rkOffset;
    logic [addrWidth-3:0]   rkIndex;
    logic                   rkRead;
    logic                   errNow;
    logic                   errRk;
    logic                   pending;
    logic                   pendErr;

    assign access = psel & penable;

    assign isKey = (paddr == keyAddr0) | (paddr == keyAddr1) |
                   (paddr == keyAddr2) | (paddr == keyAddr3);
    assign isCtrl = (paddr == ctrlAddr);
    assign isStatus = (paddr == statusAddr);
    assign isRk = (paddr >= roundKeyBase);

    assign rkOffset = paddr - roundKeyBase;
    assign rkIndex = rkOffset[addrWidth-1:2];
    assign readIdx = rkIndex[$bits(wordIdxT)-1:0];

    assign rkRead = ~pwrite & isRk;
    assign errRk = busy | (rkIndex >= numWords);

    // errors of the accesses that finish in their first access cycle
    assign errNow = ~(isKey | isCtrl | isStatus | isRk) |
                    (pwrite & isKey & busy) |
                    (pwrite & isCtrl & pwdata[0] & busy);

    assign startPulse = access & pwrite & isCtrl & pwdata[0] & ~errNow;

    // the store read is only issued for a legal index
    assign readEn = access & rkRead & ~pending & ~errRk;

    // round-key reads always finish on the second access cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            pendErr <= 1'b0;
        end else if (access & rkRead & ~pending) begin
            pending <= 1'b1;
            pendErr <= errRk;
        end else begin
            pending <= 1'b0;
            pendErr <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (access & pwrite & isKey & ~busy) begin
            cipherKey.words[paddr[3:2]] <= pwdata;
        end
    end

    assign pready = access & (~rkRead | pending);
    assign pslverr = pready & (rkRead ? pendErr : errNow);

    always_comb begin
        prdata = '0;
        if (pready & ~pslverr & ~pwrite) begin
            if (isKey) begin
                prdata = cipherKey.words[paddr[3:2]];
            end else if (isStatus) begin
                prdata = {{(wordWidth-2){1'b0}}, done, busy};
            end else if (isRk) begin
                prdata = readWord;
            end
        end
    end

endmodule

// File: roundKeyStore.sv
`timescale 1ns/1ns

module roundKeyStore import aesKeyPkg::*; (
    input  logic                 clk,
    input  logic                 writeEn,
    input  roundIdxT             writeRound,
    input  roundKeyT             writeKey,
    input  logic                 readEn,
    input  wordIdxT              readIdx,
    output logic [wordWidth-1:0] readWord
);

    logic [wordWidth-1:0] mem [0:numWords-1];
    wordIdxT              baseIdx;

    // round r occupies words 4r to 4r+3
    assign baseIdx = {writeRound, 2'b00};

    always_ff @(posedge clk) begin
        if (writeEn && writeRound <= roundIdxT'(numRounds)) begin
            for (int k = 0; k < keyWidth / wordWidth; k++) begin
                mem[baseIdx + k] <= writeKey.words[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readEn) begin
            readWord <= mem[readIdx];
        end
    end

endmodule

// File: keyExpansionCtrl.sv
`timescale 1ns/1ns

module keyExpansionCtrl import aesKeyPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     startPulse,
    input  roundKeyT cipherKey,
    output logic     busy,
    output logic     done,
    output logic     storeWrite,
    output roundIdxT storeRound,
    output roundKeyT storeKey
);

    roundKeyT keyReg;
    roundKeyT nextKey;
    roundIdxT roundCnt;

    roundKeyGen keyGen (
        .curKey  (keyReg),
        .round   (roundCnt),
        .nextKey (nextKey)
    );

    // roundCnt is the round whose key nextKey holds while busy
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            roundCnt <= '0;
        end else if (startPulse) begin
            busy <= 1'b1;
            done <= 1'b0;
            roundCnt <= roundIdxT'(1);
        end else if (busy) begin
            if (roundCnt == roundIdxT'(numRounds)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                roundCnt <= roundCnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (startPulse) begin
            keyReg <= cipherKey;
        end else if (busy) begin
            keyReg <= nextKey;
        end
    end

    // the cipher key goes to the store on the start edge itself,
    // after that one generated round key per cycle
    assign storeWrite = startPulse | busy;
    assign storeRound = startPulse ? roundIdxT'(0) : roundCnt;
    assign storeKey = startPulse ? cipherKey : nextKey;

endmodule

// File: roundKeyGen.sv
`timescale 1ns/1ns

module roundKeyGen import aesKeyPkg::*; (
    input  roundKeyT curKey,
    input  roundIdxT round,
    output roundKeyT nextKey
);

    logic [0:3][7:0]           subWord;
    logic [7:0]                rcon;
    roundIdxT                  rconIdx;
    logic [wordWidth-1:0]      tempWord;
    logic [wordWidth-1:0]      chain;

    // RotWord picks bytes 13, 14, 15, 12 of the key, then SubWord
    for (genvar i = 0; i < 4; i++) begin : sboxLane
        aesSbox sbox (
            .in  (curKey.bytes[12 + (i + 1) % 4]),
            .out (subWord[i])
        );
    end

    // round is the number of the key being produced, 1 to 10
    assign rconIdx = round - 4'd1;
    assign rcon = (round != '0 && round <= roundIdxT'(numRounds)) ? rconTable[rconIdx] : 8'h00;

    assign tempWord = subWord ^ {rcon, 24'h000000};

    // each new word is the previous new word XOR the matching old word
    always_comb begin
        chain = tempWord;
        for (int k = 0; k < keyWidth / wordWidth; k++) begin
            chain = chain ^ curKey.words[k];
            nextKey.words[k] = chain;
        end
    end

endmodule

// File: aesSbox.sv
`timescale 1ns/1ns

module aesSbox (
    input  logic [7:0] in,
    output logic [7:0] out
);

    // forward substitution table, entry 0 in the top byte
    logic [0:255][7:0] sboxTable;

    assign sboxTable = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    assign out = sboxTable[in];

endmodule

// File: aesKeyPkg.sv
package aesKeyPkg;

    // basic widths of the AES-128 key schedule and of the APB port
    localparam int wordWidth = 32;
    localparam int keyWidth = 128;
    localparam int addrWidth = 12;

    // ten rounds after the cipher key, four words per round key
    localparam int numRounds = 10;
    localparam int numWords = 44;

    typedef logic [3:0] roundIdxT;
    typedef logic [5:0] wordIdxT;

    // round constants, entry 0 belongs to round 1
    localparam logic [0:numRounds-1][7:0] rconTable = {
        8'h01,
        8'h02,
        8'h04,
        8'h08,
        8'h10,
        8'h20,
        8'h40,
        8'h80,
        8'h1b,
        8'h36
    };

    // a round key seen as words for the XOR chain or as bytes for the S-box,
    // word 0 and byte 0 both sit at the top of the vector
    typedef union packed {
        logic [0:keyWidth/wordWidth-1][wordWidth-1:0] words;
        logic [0:keyWidth/8-1][7:0]                   bytes;
    } roundKeyT;

    // APB register map
    localparam logic [addrWidth-1:0] keyAddr0 = 12'h000;
    localparam logic [addrWidth-1:0] keyAddr1 = 12'h004;
    localparam logic [addrWidth-1:0] keyAddr2 = 12'h008;
    localparam logic [addrWidth-1:0] keyAddr3 = 12'h00c;

    // bit 0 is start
    localparam logic [addrWidth-1:0] ctrlAddr = 12'h010;

    // bit 0 is busy, bit 1 is done
    localparam logic [addrWidth-1:0] statusAddr = 12'h014;

    // expanded word n is found at roundKeyBase + 4n
    localparam logic [addrWidth-1:0] roundKeyBase = 12'h100;

endpackage
